// ==== hdl/cp0_regs_pkg.sv ====
// ------------------------------------------------
// CP0 register bank definitions: register indices,
// field bit positions and the live status/cause view
// handed from the bank to the exception arbiter.
// ------------------------------------------------

package cp0_regs_pkg;

	// register index as seen on the move-to/from-CP0 path
	typedef logic [4:0] cp0_addr_t;
	// one register value
	typedef logic [31:0] cp0_word_t;

	// implemented register indices
	localparam cp0_addr_t CP0_BADVADDR = 5'd8;
	localparam cp0_addr_t CP0_COUNT = 5'd9;
	localparam cp0_addr_t CP0_COMPARE = 5'd11;
	localparam cp0_addr_t CP0_STATUS = 5'd12;
	localparam cp0_addr_t CP0_CAUSE = 5'd13;
	localparam cp0_addr_t CP0_EPC = 5'd14;
	// select 1 of index 15, select itself is not decoded
	localparam cp0_addr_t CP0_EBASE = 5'd15;

	// status fields
	localparam int STATUS_IE = 0;
	localparam int STATUS_EXL = 1;
	localparam int STATUS_IM_LO = 8;
	localparam int STATUS_IM_HI = 15;

	// cause fields
	localparam int CAUSE_IP_LO = 8;
	localparam int CAUSE_IP_HI = 15;
	// timer interrupt pending
	localparam int CAUSE_IP7 = 15;
	localparam int CAUSE_EXC_LO = 2;
	localparam int CAUSE_EXC_HI = 6;

	// live state the arbiter looks at every cycle
	typedef struct packed {
		cp0_word_t status;
		cp0_word_t cause;
	} cp0_view_t;

	// true for an index backed by a register in the bank
	function automatic logic cp0_implemented(input cp0_addr_t idx);
		case (idx)
			CP0_BADVADDR, CP0_COUNT, CP0_COMPARE, CP0_STATUS,
			CP0_CAUSE, CP0_EPC, CP0_EBASE: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

// ==== hdl/exc_pkg.sv ====
// ------------------------------------------------
// Exception definitions shared by the core input,
// the arbiter stage register and the redirect output.
// ------------------------------------------------

package exc_pkg;

	typedef logic [4:0] exc_code_t;
	// virtual address or restart address
	typedef logic [31:0] vaddr_t;
	// one bit per interrupt line, IP0..IP7
	typedef logic [7:0] exc_ip_t;

	// exception codes, same encoding as Cause.ExcCode
	localparam exc_code_t EC_INT = 5'd0;
	localparam exc_code_t EC_ADEL = 5'd4;
	localparam exc_code_t EC_ADES = 5'd5;
	localparam exc_code_t EC_SYS = 5'd8;
	localparam exc_code_t EC_BP = 5'd9;
	localparam exc_code_t EC_RI = 5'd10;
	localparam exc_code_t EC_OV = 5'd12;
	// not architectural, marks an eret travelling down the pipe
	localparam exc_code_t EC_ERET = 5'd31;

	// general exception vector, added to the ebase page
	localparam vaddr_t VEC_OFFSET = 32'h0000_0180;

	// 78 bits, core request and arbiter stage register
	typedef struct packed {
		logic valid;
		exc_code_t code;
		exc_ip_t ip;
		vaddr_t epc;
		vaddr_t badvaddr;
	} exc_req_t;

	// 33 bits, one-cycle jump request back to the core
	typedef struct packed {
		logic valid;
		vaddr_t dest;
	} redirect_t;

endpackage

// ==== hdl/apb_cp0_port.sv ====
// ------------------------------------------------
// APB completer for the move-to/from-CP0 path.
// Turns transfers into bank write strobes and reads,
// and stalls the access phase behind an exception.
// ------------------------------------------------

`timescale 1ns/1ps

module apb_cp0_port (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input cp0_regs_pkg::cp0_word_t pwdata,
	output cp0_regs_pkg::cp0_word_t prdata,
	output logic pready,
	output logic pslverr,
	// bank side
	output logic wr_en,
	output cp0_regs_pkg::cp0_addr_t wr_addr,
	output cp0_regs_pkg::cp0_word_t wr_data,
	output cp0_regs_pkg::cp0_addr_t rd_addr,
	input cp0_regs_pkg::cp0_word_t rd_data,
	// exception in flight in the bank stage
	input logic stall
);

	import cp0_regs_pkg::*;

	// IDLE: nothing outstanding
	// SETUP: setup phase seen, first access cycle due now
	// ACCESS: an access cycle was held, still waiting
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} apb_state_t;

	apb_state_t state;
	apb_state_t next_state;
	cp0_addr_t idx;
	logic idx_ok;
	logic access;
	logic xfer_done;

	// word index sits in paddr[6:2], anything outside that window is unmapped
	assign idx = paddr[6:2];
	assign idx_ok = (paddr[31:7] == '0) && (paddr[1:0] == 2'b00) && cp0_implemented(idx);

	assign access = psel && penable;

	// only back-pressure is an exception sitting in the stage register
	assign pready = !(access && stall);

	// completing edge, but only once per transfer
	assign xfer_done = access && pready && (state != IDLE);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (psel && !penable)
					next_state = SETUP;
			end
			SETUP, ACCESS: begin
				if (!psel || xfer_done)
					next_state = IDLE;
				else if (access)
					next_state = ACCESS;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// write lands in the bank on the completing edge
	assign wr_en = xfer_done && pwrite && idx_ok;
	assign wr_addr = idx;
	assign wr_data = pwdata;

	// read returns the value before the edge, zero for unmapped
	assign rd_addr = idx;
	assign prdata = idx_ok ? rd_data : '0;
	assign pslverr = access && !idx_ok;

endmodule

// ==== hdl/exc_arbiter.sv ====
// ------------------------------------------------
// Exception arbiter, first pipeline stage.
// Merges core exceptions, external pins and the timer
// into one registered request for the CP0 bank.
// ------------------------------------------------

`timescale 1ns/1ps

module exc_arbiter #(
	// at most six, mapped to IP2 and up
	parameter int N_HW_INT = 6
) (
	input logic clk,
	input logic rst,
	input exc_pkg::exc_req_t core_exc,
	// restart address recorded when an interrupt is taken
	input exc_pkg::vaddr_t int_epc,
	input logic [N_HW_INT-1:0] hw_int,
	input cp0_regs_pkg::cp0_view_t view,
	output exc_pkg::exc_req_t stage
);

	import cp0_regs_pkg::*;
	import exc_pkg::*;

	logic [5:0] hw_ip;
	exc_ip_t pending;
	exc_ip_t masked;
	logic int_ok;

	// spread the pins over the six hardware lines
	always_comb begin
		hw_ip = '0;
		hw_ip[N_HW_INT-1:0] = hw_int;
	end

	// timer shares IP7 with the last hardware line
	// software bits IP1:0 never raise an interrupt
	assign pending = {hw_ip[5] | view.cause[CAUSE_IP7], hw_ip[4:0], 2'b00};

	assign masked = pending & view.status[STATUS_IM_HI:STATUS_IM_LO];

	// no interrupt while in exception level or with one already queued
	assign int_ok = (|masked) &&
		view.status[STATUS_IE] &&
		!view.status[STATUS_EXL] &&
		!stage.valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage.valid <= 1'b0;
		end else if (core_exc.valid) begin
			// synchronous exception or eret wins over interrupts
			stage <= core_exc;
			// core's own ip field is ignored
			stage.ip <= pending;
		end else if (int_ok) begin
			stage.valid <= 1'b1;
			stage.code <= EC_INT;
			stage.ip <= pending;
			stage.epc <= int_epc;
			stage.badvaddr <= '0;
		end else begin
			stage.valid <= 1'b0;
		end
	end

endmodule

// ==== hdl/cp0_regs.sv ====
// ------------------------------------------------
// CP0 register bank, second pipeline stage.
// Holds the exception registers and count/compare timer,
// applies exception entry and eret from the stage
// register, and raises a one-cycle redirect.
// ------------------------------------------------

`timescale 1ns/1ps

module cp0_regs (
	input logic clk,
	input logic rst,
	input exc_pkg::exc_req_t stage,
	// move-to-CP0 write port
	input logic wr_en,
	input cp0_regs_pkg::cp0_addr_t wr_addr,
	input cp0_regs_pkg::cp0_word_t wr_data,
	// move-from-CP0 read port, combinational
	input cp0_regs_pkg::cp0_addr_t rd_addr,
	output cp0_regs_pkg::cp0_word_t rd_data,
	output cp0_regs_pkg::cp0_view_t view,
	output exc_pkg::redirect_t redirect
);

	import cp0_regs_pkg::*;
	import exc_pkg::*;

	cp0_word_t badvaddr;
	cp0_word_t count;
	cp0_word_t compare;
	cp0_word_t status;
	cp0_word_t cause;
	cp0_word_t epc;
	cp0_word_t ebase;

	logic timer_hit;
	logic cmp_wr;
	vaddr_t vector;

	// compare of zero never fires
	assign timer_hit = (count == compare) && (compare != '0);

	// exceptions take priority, so a write only counts without one
	assign cmp_wr = wr_en && !stage.valid && (wr_addr == CP0_COMPARE);

	// kseg-style top bits, ebase page plus general offset
	assign vector = {2'b10, ebase[29:12], 12'h000} + VEC_OFFSET;

	always_ff @(posedge clk) begin
		if (rst) begin
			badvaddr <= '0;
			count <= '0;
			compare <= '0;
			status <= '0;
			cause <= '0;
			epc <= '0;
			ebase <= '0;
			redirect.valid <= 1'b0;
		end else begin
			count <= count + 32'd1;
			// redirect is a single-cycle pulse
			redirect.valid <= 1'b0;

			if (stage.valid) begin
				redirect.valid <= 1'b1;
				if (stage.code == EC_ERET) begin
					status[STATUS_EXL] <= 1'b0;
					redirect.dest <= epc;
				end else begin
					redirect.dest <= vector;
					// nested entry leaves all state alone and only jumps
					if (!status[STATUS_EXL]) begin
						epc <= stage.epc;
						badvaddr <= stage.badvaddr;
						// software bits IP1:0 keep their stored value
						cause[CAUSE_IP_HI:CAUSE_IP_LO+2] <= stage.ip[7:2];
						cause[CAUSE_EXC_HI:CAUSE_EXC_LO] <= stage.code;
						status[STATUS_EXL] <= 1'b1;
					end
				end
			end else if (wr_en) begin
				case (wr_addr)
					CP0_BADVADDR: badvaddr <= wr_data;
					CP0_COUNT: count <= wr_data;
					CP0_COMPARE: begin
						compare <= wr_data;
						// acknowledges the timer interrupt
						cause[CAUSE_IP7] <= 1'b0;
					end
					CP0_STATUS: status <= wr_data;
					CP0_CAUSE: cause <= wr_data;
					CP0_EPC: epc <= wr_data;
					CP0_EBASE: ebase <= wr_data;
					default: ;
				endcase
			end

			// a match sets IP7 unless compare is being rewritten this edge
			if (timer_hit && !cmp_wr)
				cause[CAUSE_IP7] <= 1'b1;
		end
	end

	always_comb begin
		case (rd_addr)
			CP0_BADVADDR: rd_data = badvaddr;
			CP0_COUNT: rd_data = count;
			CP0_COMPARE: rd_data = compare;
			CP0_STATUS: rd_data = status;
			CP0_CAUSE: rd_data = cause;
			CP0_EPC: rd_data = epc;
			CP0_EBASE: rd_data = ebase;
			default: rd_data = '0;
		endcase
	end

	assign view.status = status;
	assign view.cause = cause;

endmodule

// ==== hdl/cp0_top.sv ====
// ------------------------------------------------
// CP0 exception subsystem top level.
// APB register port, exception arbiter and register
// bank, two cycles from event to redirect.
// ------------------------------------------------

`timescale 1ns/1ps

module cp0_top #(
	parameter int N_HW_INT = 6
) (
	input logic clk,
	input logic rst,
	// APB completer
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input cp0_regs_pkg::cp0_word_t pwdata,
	output cp0_regs_pkg::cp0_word_t prdata,
	output logic pready,
	output logic pslverr,
	// core exception side
	input exc_pkg::exc_req_t core_exc,
	input exc_pkg::vaddr_t int_epc,
	input logic [N_HW_INT-1:0] hw_int,
	output exc_pkg::redirect_t redirect
);

	import cp0_regs_pkg::*;
	import exc_pkg::*;

	exc_req_t stage;
	cp0_view_t view;
	logic wr_en;
	cp0_addr_t wr_addr;
	cp0_word_t wr_data;
	cp0_addr_t rd_addr;
	cp0_word_t rd_data;

	apb_cp0_port i_apb (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		// hold APB off while an exception is being applied
		.stall(stage.valid)
	);

	exc_arbiter #(
		.N_HW_INT(N_HW_INT)
	) i_arb (
		.clk(clk),
		.rst(rst),
		.core_exc(core_exc),
		.int_epc(int_epc),
		.hw_int(hw_int),
		.view(view),
		.stage(stage)
	);

	cp0_regs i_regs (
		.clk(clk),
		.rst(rst),
		.stage(stage),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.view(view),
		.redirect(redirect)
	);

endmodule

// ==== dv/tb_clkgen.sv ====
// ------------------------------------------------
// Testbench clock and reset source.
// 8 ns clock, synchronous reset high for five cycles.
// ------------------------------------------------

`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// released on the fifth rising edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== dv/tb_cp0.sv ====
// ------------------------------------------------
// Testbench for the CP0 exception subsystem.
// APB register traffic, core events and interrupt pins
// are checked against a shadow model of EXL, EPC, EBase.
// ------------------------------------------------

`timescale 1ns/1ps

module tb_cp0;

	import cp0_regs_pkg::*;
	import exc_pkg::*;

	localparam int LIMIT = 4000;

	logic clk, rst, psel, penable, pwrite, pready, pslverr;
	logic [31:0] paddr;
	cp0_word_t pwdata, prdata;
	exc_req_t core_exc;
	vaddr_t int_epc;
	logic [5:0] hw_int;
	redirect_t redirect;

	// shadow model
	logic m_exl;
	vaddr_t m_epc, m_ebase, m_badv;
	int errors = 0;
	int checks = 0;
	int cycle = 0;
	int test_base, tests_run = 0, tests_failed = 0;
	exc_code_t sync_codes[6] = '{EC_ADEL, EC_ADES, EC_SYS, EC_BP, EC_RI, EC_OV};
	cp0_addr_t zero_regs[6] = '{CP0_BADVADDR, CP0_COMPARE, CP0_STATUS, CP0_CAUSE,
		CP0_EPC, CP0_EBASE};
	cp0_addr_t rw_regs[4] = '{CP0_EBASE, CP0_EPC, CP0_STATUS, CP0_COMPARE};

	tb_clkgen i_clk (.clk(clk), .rst(rst));

	cp0_top #(.N_HW_INT(6)) i_dut (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .core_exc(core_exc), .int_epc(int_epc), .hw_int(hw_int),
		.redirect(redirect)
	);

	// redirect is a one-cycle pulse
	redirect_pulse: assert property (@(posedge clk) disable iff (rst)
		redirect.valid |=> !redirect.valid)
	else begin
		errors++;
		$display("redirect.valid stayed high for more than one cycle");
	end

	// core event to redirect in exactly two cycles
	event_latency: assert property (@(posedge clk) disable iff (rst)
		core_exc.valid |-> ##1 !redirect.valid ##1 redirect.valid)
	else begin
		errors++;
		$display("redirect did not follow a core event two cycles later");
	end

	// cycle count, also the run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	// general vector, top bits 10 plus the ebase page plus 0x180
	function automatic vaddr_t vector_of(input vaddr_t ebase);
		return ((ebase & 32'h3fff_f000) | 32'h8000_0000) + 32'h0000_0180;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic note_error(input string what);
		errors++;
		$display("error: %s", what);
	endtask

	// one APB transfer, returns data, error, stall cycles and completing cycle
	task automatic apb_xfer(input logic write, input cp0_addr_t idx, input cp0_word_t wdata,
			output cp0_word_t rdata, output logic slverr, output int waits, output int at);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= {25'd0, idx, 2'b00};
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		waits = 0;
		@(posedge clk);
		while (!pready) begin
			waits++;
			@(posedge clk);
		end
		rdata = prdata;
		slverr = pslverr;
		at = cycle;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input cp0_addr_t idx, input cp0_word_t data);
		cp0_word_t rd;
		logic err;
		int w, at;
		apb_xfer(1'b1, idx, data, rd, err, w, at);
		assert (!err)
		else note_error($sformatf("pslverr on write to index %0d", idx));
	endtask

	// read a register and compare the masked bits
	task automatic expect_reg(input string name, input cp0_addr_t idx,
			input cp0_word_t mask, input cp0_word_t exp);
		cp0_word_t rd;
		logic err;
		int w, at;
		apb_xfer(1'b0, idx, '0, rd, err, w, at);
		check_word(name, rd & mask, exp & mask);
	endtask

	task automatic wait_redirect(input int limit, output logic seen, output vaddr_t dest);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(posedge clk);
			if (redirect.valid) begin
				seen = 1'b1;
				dest = redirect.dest;
			end
		end
	endtask

	task automatic expect_no_redirect(input int n);
		repeat (n) begin
			@(posedge clk);
			assert (!redirect.valid)
			else note_error("redirect appeared while the interrupt should be blocked");
		end
	endtask

	// core holds the event for one cycle
	task automatic send_event(input exc_code_t code, input vaddr_t epc, input vaddr_t badv,
			output vaddr_t dest);
		logic seen;
		@(posedge clk);
		core_exc <= '{valid: 1'b1, code: code, ip: 8'h00, epc: epc, badvaddr: badv};
		@(posedge clk);
		core_exc.valid <= 1'b0;
		wait_redirect(8, seen, dest);
		assert (seen)
		else note_error("no redirect after a core event");
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors > test_base) begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_base);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		test_base = errors;
	endtask

	initial begin
		vaddr_t dest, e_epc, e_badv, iepc;
		cp0_word_t rd, wv, c1;
		exc_code_t code;
		logic err, seen;
		int w, t1, t2, p;
		void'($urandom(32'h67ea1d9d));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		core_exc = '0;
		int_epc = '0;
		hw_int = '0;
		m_exl = 1'b0;
		m_epc = '0;
		m_ebase = '0;
		m_badv = '0;
		wait (!rst);
		test_base = errors;

		@(posedge clk);
		check_word("pready", {31'd0, pready}, 32'd1);
		foreach (zero_regs[i])
			expect_reg($sformatf("prdata[%0d]", zero_regs[i]), zero_regs[i], '1, '0);
		foreach (rw_regs[i]) begin
			wv = $urandom;
			write_reg(rw_regs[i], wv);
			expect_reg($sformatf("prdata[%0d]", rw_regs[i]), rw_regs[i], '1, wv);
			if (rw_regs[i] == CP0_EBASE)
				m_ebase = wv;
			if (rw_regs[i] == CP0_EPC)
				m_epc = wv;
		end
		write_reg(CP0_STATUS, '0);
		write_reg(CP0_COMPARE, '0);
		// index 3 is not implemented
		apb_xfer(1'b0, 5'd3, '0, rd, err, w, t1);
		check_word("pslverr", {31'd0, err}, 32'd1);
		check_word("prdata", rd, '0);
		apb_xfer(1'b1, 5'd3, $urandom, rd, err, w, t1);
		check_word("pslverr", {31'd0, err}, 32'd1);
		// count advances once per cycle between the two sample edges
		apb_xfer(1'b0, CP0_COUNT, '0, c1, err, w, t1);
		repeat (2 + $urandom % 10) @(posedge clk);
		apb_xfer(1'b0, CP0_COUNT, '0, rd, err, w, t2);
		check_word("count delta", rd - c1, t2 - t1);
		end_test("reset and register access");

		code = sync_codes[$urandom % 6];
		e_epc = $urandom;
		e_badv = $urandom;
		send_event(code, e_epc, e_badv, dest);
		check_word("redirect.dest", dest, vector_of(m_ebase));
		m_epc = e_epc;
		m_badv = e_badv;
		m_exl = 1'b1;
		expect_reg("epc", CP0_EPC, '1, m_epc);
		expect_reg("badvaddr", CP0_BADVADDR, '1, m_badv);
		expect_reg("cause.exc", CP0_CAUSE, 32'h7c, {25'd0, code, 2'b00});
		expect_reg("status.exl", CP0_STATUS, 32'h2, {30'd0, m_exl, 1'b0});
		end_test("exception with EXL clear");

		// nested entry only jumps
		send_event(sync_codes[$urandom % 6], $urandom, $urandom, dest);
		check_word("redirect.dest", dest, vector_of(m_ebase));
		expect_reg("epc", CP0_EPC, '1, m_epc);
		expect_reg("badvaddr", CP0_BADVADDR, '1, m_badv);
		end_test("exception with EXL set");

		send_event(EC_ERET, $urandom, '0, dest);
		check_word("redirect.dest", dest, m_epc);
		m_exl = 1'b0;
		expect_reg("status.exl", CP0_STATUS, 32'h2, '0);
		end_test("eret");

		// pin p lands on IP(p+2), enabled by IM bit 10+p
		p = $urandom % 6;
		iepc = $urandom;
		write_reg(CP0_STATUS, 32'h1 | (32'h400 << p));
		@(posedge clk);
		int_epc <= iepc;
		hw_int <= 6'b1 << p;
		wait_redirect(10, seen, dest);
		assert (seen)
		else note_error("no redirect for an enabled external interrupt");
		check_word("redirect.dest", dest, vector_of(m_ebase));
		@(posedge clk);
		hw_int <= '0;
		m_epc = iepc;
		m_exl = 1'b1;
		expect_reg("epc", CP0_EPC, '1, m_epc);
		expect_reg("cause.exc", CP0_CAUSE, 32'h7c, {25'd0, EC_INT, 2'b00});
		expect_reg("cause.ip", CP0_CAUSE, 32'h400 << p, 32'h400 << p);
		// still in exception level
		@(posedge clk);
		hw_int <= 6'b1 << p;
		expect_no_redirect(20);
		hw_int <= '0;
		// IE only, IM clear, also leaves exception level
		write_reg(CP0_STATUS, 32'h1);
		m_exl = 1'b0;
		@(posedge clk);
		hw_int <= 6'b1 << p;
		expect_no_redirect(20);
		hw_int <= '0;
		end_test("external interrupt");

		// timer on IP7, compare placed a little ahead of count
		iepc = $urandom;
		// a pin on the last line may have left IP7 set in Cause
		write_reg(CP0_COMPARE, '0);
		write_reg(CP0_STATUS, 32'h8001);
		apb_xfer(1'b0, CP0_COUNT, '0, c1, err, w, t1);
		@(posedge clk);
		int_epc <= iepc;
		write_reg(CP0_COMPARE, c1 + 32'd24);
		wait_redirect(64, seen, dest);
		assert (seen)
		else note_error("no interrupt entry after a compare match");
		check_word("redirect.dest", dest, vector_of(m_ebase));
		m_epc = iepc;
		m_exl = 1'b1;
		expect_reg("cause.ip7", CP0_CAUSE, 32'h8000, 32'h8000);
		expect_reg("epc", CP0_EPC, '1, m_epc);
		write_reg(CP0_COMPARE, '0);
		expect_reg("cause.ip7", CP0_CAUSE, 32'h8000, '0);
		// access phase lines up with the exception in the stage register
		wv = $urandom;
		fork
			send_event(sync_codes[$urandom % 6], $urandom, $urandom, dest);
			apb_xfer(1'b1, CP0_BADVADDR, wv, rd, err, w, t1);
		join
		check_word("redirect.dest", dest, vector_of(m_ebase));
		check_word("pready low cycles", w, 32'd1);
		expect_reg("badvaddr", CP0_BADVADDR, '1, wv);
		expect_reg("epc", CP0_EPC, '1, m_epc);
		end_test("timer and APB stall");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/cp0_regs_pkg.sv
hdl/exc_pkg.sv
hdl/apb_cp0_port.sv
hdl/exc_arbiter.sv
hdl/cp0_regs.sv
hdl/cp0_top.sv
dv/tb_clkgen.sv
dv/tb_cp0.sv

// ==== Bender.yml ====
package:
  name: cp0_exc

sources:
  # packages first, then the RTL from the leaves up
  - hdl/cp0_regs_pkg.sv
  - hdl/exc_pkg.sv
  - hdl/apb_cp0_port.sv
  - hdl/exc_arbiter.sv
  - hdl/cp0_regs.sv
  - hdl/cp0_top.sv

  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/tb_cp0.sv
